//--- logic/glyph_fetch_if.sv
`timescale 1ns/1ps

// one row fetch channel, sprite engine to rom arbiter
interface glyph_fetch_if;
   import logo_pkg::*;

   // four-phase handshake
   logic       req;
   logic       ack;
   // request payload, held while req is high
   glyph_id_t  glyph;
   row_idx_t   row;
   // valid while ack is high
   glyph_row_t data;

   modport client (
      output req, glyph, row,
      input  ack, data
   );

   modport target (
      input  req, glyph, row,
      output ack, data
   );

endinterface

//--- logic/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
   input  logic                 clk,
   input  logic [5:0]           rom_addr,
   output logo_pkg::glyph_row_t rom_data
);
   import logo_pkg::*;

   // row shapes, bit 0 is the leftmost column so the literals read mirrored
   localparam glyph_row_t ROW_BAR   = 32'b0000_0000_0001_1111_1111_1000_0000_0000;
   localparam glyph_row_t ROW_WIDE  = 32'b0000_0000_0011_1111_1111_1100_0000_0000;
   localparam glyph_row_t ROW_SIDES = 32'b0000_0000_0011_1000_0001_1100_0000_0000;
   // right stroke, columns 19 to 21
   localparam glyph_row_t ROW_RIGHT = 32'b0000_0000_0011_1000_0000_0000_0000_0000;
   localparam glyph_row_t ROW_MID   = 32'b0000_0000_0000_0111_0000_0000_0000_0000;
   localparam glyph_row_t ROW_STEM  = 32'b0000_0000_0000_0011_1000_0000_0000_0000;
   // hook of the one, leaning left
   localparam glyph_row_t ROW_FLAG  = 32'b0000_0000_0000_0011_1110_0000_0000_0000;
   localparam glyph_row_t ROW_BASE  = 32'b0000_0000_0000_1111_1111_0000_0000_0000;

   glyph_id_t  glyph;
   row_idx_t   row;
   glyph_row_t rom_row;

   // address is glyph id then row
   assign glyph = glyph_id_t'(rom_addr[5:4]);
   assign row   = rom_addr[3:0];

   always_comb
   begin
      rom_row = '0;
      case (glyph)
         GLYPH_ZERO:
            case (row) inside
               4'd0, 4'd15: rom_row = ROW_BAR;
               4'd1, 4'd14: rom_row = ROW_WIDE;
               default:     rom_row = ROW_SIDES;
            endcase
         GLYPH_ONE:
            case (row) inside
               4'd1, 4'd2:   rom_row = ROW_FLAG;
               4'd14, 4'd15: rom_row = ROW_BASE;
               default:      rom_row = ROW_STEM;
            endcase
         GLYPH_SEVEN:
            case (row) inside
               [4'd0:4'd1]: rom_row = ROW_WIDE;
               [4'd2:4'd7]: rom_row = ROW_RIGHT;
               default:     rom_row = ROW_MID;
            endcase
         GLYPH_EIGHT:
            // two stacked loops
            case (row) inside
               4'd0, 4'd7, 4'd8, 4'd15: rom_row = ROW_BAR;
               4'd1, 4'd14:             rom_row = ROW_WIDE;
               default:                 rom_row = ROW_SIDES;
            endcase
         default: rom_row = '0;
      endcase
   end

   // one clock read latency
   always_ff @(posedge clk)
      rom_data <= rom_row;

endmodule

//--- logic/logo_display.sv
`timescale 1ns/1ps

module logo_display #(
   parameter int                  N_SPRITES = 3,
   parameter logo_pkg::rgb_t      BG_RGB    = 3'b001,
   // sprite 0, eight in magenta
   parameter logo_pkg::coord_t    S0_X      = 10'd300,
   parameter logo_pkg::coord_t    S0_Y      = 10'd10,
   parameter logo_pkg::glyph_id_t S0_GLYPH  = logo_pkg::GLYPH_EIGHT,
   parameter logo_pkg::rgb_t      S0_COLOR  = 3'b101,
   // sprite 1, zero in cyan, overlaps sprite 0
   parameter logo_pkg::coord_t    S1_X      = 10'd316,
   parameter logo_pkg::coord_t    S1_Y      = 10'd18,
   parameter logo_pkg::glyph_id_t S1_GLYPH  = logo_pkg::GLYPH_ZERO,
   parameter logo_pkg::rgb_t      S1_COLOR  = 3'b011,
   // sprite 2, seven in yellow, same lines as sprite 0
   parameter logo_pkg::coord_t    S2_X      = 10'd100,
   parameter logo_pkg::coord_t    S2_Y      = 10'd10,
   parameter logo_pkg::glyph_id_t S2_GLYPH  = logo_pkg::GLYPH_SEVEN,
   parameter logo_pkg::rgb_t      S2_COLOR  = 3'b110
) (
   input  logic       clk,
   input  logic       reset,
   output logic       hsync,
   output logic       vsync,
   output logic [2:0] rgb
);
   import logo_pkg::*;

   coord_t               pix_x;
   coord_t               pix_y;
   logic                 active;
   logic                 line_start;
   logic                 raw_hsync;
   logic                 raw_vsync;
   logic [5:0]           rom_addr;
   glyph_row_t           rom_data;
   logic [N_SPRITES-1:0] sprite_on;
   rgb_t                 sprite_rgb [N_SPRITES];

   // one fetch channel per sprite
   glyph_fetch_if fetch_bus [N_SPRITES] ();

   vga_sync u_sync (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .active     (active),
      .line_start (line_start),
      .hsync      (raw_hsync),
      .vsync      (raw_vsync)
   );

   // ------------------------------
   // shared glyph store
   // ------------------------------
   glyph_rom u_rom (
      .clk      (clk),
      .rom_addr (rom_addr),
      .rom_data (rom_data)
   );

   rom_arbiter #(
      .N_SPRITES (N_SPRITES)
   ) u_arb (
      .clk      (clk),
      .reset    (reset),
      .clients  (fetch_bus),
      .rom_addr (rom_addr),
      .rom_data (rom_data)
   );

   // ------------------------------
   // sprites
   // ------------------------------
   sprite_engine #(
      .X_POS (S0_X),
      .Y_POS (S0_Y),
      .GLYPH (S0_GLYPH),
      .COLOR (S0_COLOR)
   ) u_sprite0 (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .line_start (line_start),
      .fetch      (fetch_bus[0]),
      .sprite_on  (sprite_on[0]),
      .sprite_rgb (sprite_rgb[0])
   );

   sprite_engine #(
      .X_POS (S1_X),
      .Y_POS (S1_Y),
      .GLYPH (S1_GLYPH),
      .COLOR (S1_COLOR)
   ) u_sprite1 (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .line_start (line_start),
      .fetch      (fetch_bus[1]),
      .sprite_on  (sprite_on[1]),
      .sprite_rgb (sprite_rgb[1])
   );

   sprite_engine #(
      .X_POS (S2_X),
      .Y_POS (S2_Y),
      .GLYPH (S2_GLYPH),
      .COLOR (S2_COLOR)
   ) u_sprite2 (
      .clk        (clk),
      .reset      (reset),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .line_start (line_start),
      .fetch      (fetch_bus[2]),
      .sprite_on  (sprite_on[2]),
      .sprite_rgb (sprite_rgb[2])
   );

   // output colour and syncs, one clock behind the counters
   pixel_compositor #(
      .N_SPRITES (N_SPRITES),
      .BG_RGB    (BG_RGB)
   ) u_comp (
      .clk        (clk),
      .reset      (reset),
      .active     (active),
      .hsync_in   (raw_hsync),
      .vsync_in   (raw_vsync),
      .sprite_on  (sprite_on),
      .sprite_rgb (sprite_rgb),
      .rgb        (rgb),
      .hsync      (hsync),
      .vsync      (vsync)
   );

endmodule

//--- logic/logo_pkg.sv
package logo_pkg;

   // ------------------------------
   // shared types
   // ------------------------------
   // screen coordinate, pixel or line
   typedef logic [9:0] coord_t;
   // bit 2 red, bit 1 green, bit 0 blue
   typedef logic [2:0] rgb_t;
   typedef logic [1:0] glyph_id_t;
   typedef logic [3:0] row_idx_t;
   // bit n is pixel column n from the left edge
   typedef logic [31:0] glyph_row_t;

   // glyph size in pixels
   localparam int GLYPH_W = 32;
   localparam int GLYPH_H = 16;

   // ------------------------------
   // 640x480 timing
   // ------------------------------
   localparam int H_ACTIVE = 640;
   localparam int H_FRONT  = 16;
   localparam int H_SYNC   = 96;
   localparam int H_BACK   = 48;
   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   // vertical, in lines
   localparam int V_ACTIVE = 480;
   localparam int V_FRONT  = 10;
   localparam int V_SYNC   = 2;
   localparam int V_BACK   = 33;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   // glyph ids, upper rom address bits
   localparam glyph_id_t GLYPH_ZERO  = 2'd0;
   localparam glyph_id_t GLYPH_ONE   = 2'd1;
   localparam glyph_id_t GLYPH_SEVEN = 2'd2;
   localparam glyph_id_t GLYPH_EIGHT = 2'd3;

endpackage

//--- logic/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor #(
   parameter int             N_SPRITES = 3,
   parameter logo_pkg::rgb_t BG_RGB    = 3'b001
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 active,
   input  logic                 hsync_in,
   input  logic                 vsync_in,
   input  logic [N_SPRITES-1:0] sprite_on,
   input  logo_pkg::rgb_t       sprite_rgb [N_SPRITES],
   output logo_pkg::rgb_t       rgb,
   output logic                 hsync,
   output logic                 vsync
);
   import logo_pkg::*;

   rgb_t pixel;

   // ------------------------------
   // priority merge
   // ------------------------------
   always_comb
   begin
      pixel = BG_RGB;
      // walk down so the lowest index wins
      for (int k = N_SPRITES - 1; k >= 0; k--)
         if (sprite_on[k])
            pixel = sprite_rgb[k];
      // black outside the visible area
      if (!active)
         pixel = '0;
   end

   // ------------------------------
   // output stage
   // ------------------------------
   // syncs delayed with the colour so they stay paired
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rgb   <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end
      else
      begin
         rgb   <= pixel;
         hsync <= hsync_in;
         vsync <= vsync_in;
      end
   end

endmodule

//--- logic/rom_arbiter.sv
`timescale 1ns/1ps

module rom_arbiter #(
   parameter int N_SPRITES = 3
) (
   input  logic                 clk,
   input  logic                 reset,
   glyph_fetch_if.target        clients [N_SPRITES],
   output logic [5:0]           rom_addr,
   input  logo_pkg::glyph_row_t rom_data
);
   import logo_pkg::*;

   localparam int IDX_W = (N_SPRITES > 1) ? $clog2(N_SPRITES) : 1;

   // grant, rom read, ack, wait for req low
   typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_ACK, ST_RELEASE} arb_state_t;

   arb_state_t           state;
   logic [IDX_W-1:0]     grant;
   logic [IDX_W-1:0]     pick;
   logic                 found;
   logic                 ack_on;
   logic [N_SPRITES-1:0] req_vec;
   glyph_id_t            glyph_vec [N_SPRITES];
   row_idx_t             row_vec [N_SPRITES];

   // ------------------------------
   // per client wiring
   // ------------------------------
   for (genvar i = 0; i < N_SPRITES; i++)
   begin : g_client
      assign req_vec[i]      = clients[i].req;
      assign glyph_vec[i]    = clients[i].glyph;
      assign row_vec[i]      = clients[i].row;
      // only the granted client sees ack and data
      assign clients[i].ack  = ack_on && (grant == IDX_W'(i));
      assign clients[i].data = (grant == IDX_W'(i)) ? rom_data : '0;
   end

   // round robin, search starts after the last grant
   always_comb
   begin
      int cand;
      found = 1'b0;
      pick  = grant;
      for (int k = 1; k <= N_SPRITES; k++)
      begin
         cand = (int'(grant) + k) % N_SPRITES;
         if (!found && req_vec[cand])
         begin
            found = 1'b1;
            pick  = IDX_W'(cand);
         end
      end
   end

   // ack held through release until req falls
   assign ack_on = (state == ST_ACK) || (state == ST_RELEASE);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         // so client 0 is served first
         grant <= IDX_W'(N_SPRITES - 1);
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (found)
               begin
                  grant <= pick;
                  state <= ST_READ;
               end
            ST_READ:    state <= ST_ACK;
            ST_ACK:     state <= ST_RELEASE;
            ST_RELEASE:
               if (!req_vec[grant])
                  state <= ST_IDLE;
            default:    state <= ST_IDLE;
         endcase
      end
   end

   // address latched at grant, held until the next grant
   always_ff @(posedge clk)
      if (state == ST_IDLE && found)
         rom_addr <= {glyph_vec[pick], row_vec[pick]};

endmodule

//--- logic/sprite_engine.sv
`timescale 1ns/1ps

module sprite_engine #(
   parameter logo_pkg::coord_t    X_POS = 10'd0,
   parameter logo_pkg::coord_t    Y_POS = 10'd0,
   parameter logo_pkg::glyph_id_t GLYPH = logo_pkg::GLYPH_ZERO,
   parameter logo_pkg::rgb_t      COLOR = 3'b111
) (
   input  logic             clk,
   input  logic             reset,
   input  logo_pkg::coord_t pix_x,
   input  logo_pkg::coord_t pix_y,
   input  logic             line_start,
   glyph_fetch_if.client    fetch,
   output logic             sprite_on,
   output logo_pkg::rgb_t   sprite_rgb
);
   import logo_pkg::*;

   localparam int COL_W = $clog2(GLYPH_W);

   typedef enum logic [1:0] {F_IDLE, F_REQ, F_DONE} fetch_state_t;

   fetch_state_t     fstate;
   coord_t           next_y;
   logic             covers;
   logic             line_end;
   logic             in_x;
   logic             req_r;
   row_idx_t         row_r;
   glyph_row_t       fetch_row;
   glyph_row_t       display_row;
   logic [COL_W-1:0] col;

   // ------------------------------
   // next line coverage
   // ------------------------------
   // wraps after the last line of the frame
   assign next_y   = (pix_y == coord_t'(V_TOTAL - 1)) ? '0 : pix_y + 10'd1;
   assign covers   = (next_y >= Y_POS) && (next_y < Y_POS + GLYPH_H);
   // last clock of the line, row goes live at pixel 0
   assign line_end = (pix_x == coord_t'(H_TOTAL - 1));

   // request side of the handshake
   assign fetch.req   = req_r;
   assign fetch.glyph = GLYPH;
   assign fetch.row   = row_r;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         fstate <= F_IDLE;
         req_r  <= 1'b0;
      end
      else
      begin
         case (fstate)
            F_IDLE:
               if (line_start && covers)
               begin
                  req_r  <= 1'b1;
                  fstate <= F_REQ;
               end
            // wait until served
            F_REQ:
               if (fetch.ack)
               begin
                  req_r  <= 1'b0;
                  fstate <= F_DONE;
               end
            // no new req before ack is low
            F_DONE:
               if (!fetch.ack)
                  fstate <= F_IDLE;
            default: fstate <= F_IDLE;
         endcase
      end
   end

   // glyph row for the next line
   always_ff @(posedge clk)
      if (line_start && covers)
         row_r <= row_idx_t'(next_y - Y_POS);

   // ------------------------------
   // fetch and display rows
   // ------------------------------
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         fetch_row   <= '0;
         display_row <= '0;
      end
      else
      begin
         // uncovered line shows nothing
         if (line_start && !covers)
            fetch_row <= '0;
         if (fstate == F_REQ && fetch.ack)
            fetch_row <= fetch.data;
         if (line_end)
            display_row <= fetch_row;
      end
   end

   // ------------------------------
   // pixel lookup
   // ------------------------------
   assign in_x       = (pix_x >= X_POS) && (pix_x < X_POS + GLYPH_W);
   assign col        = COL_W'(pix_x - X_POS);
   assign sprite_on  = in_x && display_row[col];
   assign sprite_rgb = COLOR;

endmodule

//--- logic/vga_sync.sv
`timescale 1ns/1ps

module vga_sync (
   input  logic             clk,
   input  logic             reset,
   output logo_pkg::coord_t pix_x,
   output logo_pkg::coord_t pix_y,
   output logic             active,
   output logic             line_start,
   output logic             hsync,
   output logic             vsync
);
   import logo_pkg::*;

   // sync windows, counted from pixel 0
   localparam int HS_START = H_ACTIVE + H_FRONT;
   localparam int HS_END   = HS_START + H_SYNC;
   localparam int VS_START = V_ACTIVE + V_FRONT;
   localparam int VS_END   = VS_START + V_SYNC;

   coord_t x_next;
   coord_t y_next;
   logic   h_wrap;

   // ------------------------------
   // counter next state
   // ------------------------------
   assign h_wrap = (pix_x == coord_t'(H_TOTAL - 1));
   assign x_next = h_wrap ? '0 : pix_x + 10'd1;

   always_comb
   begin
      y_next = pix_y;
      // line advances only at the end of a line
      if (h_wrap)
         y_next = (pix_y == coord_t'(V_TOTAL - 1)) ? '0 : pix_y + 10'd1;
   end

   // ------------------------------
   // counters and decoded flags
   // ------------------------------
   // flags decoded from next values so they line up with the counters
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pix_x      <= '0;
         pix_y      <= '0;
         active     <= 1'b0;
         line_start <= 1'b0;
         hsync      <= 1'b1;
         vsync      <= 1'b1;
      end
      else
      begin
         pix_x      <= x_next;
         pix_y      <= y_next;
         active     <= (x_next < H_ACTIVE) && (y_next < V_ACTIVE);
         // first blanking pixel of every line
         line_start <= (x_next == coord_t'(H_ACTIVE));
         // both syncs active low
         hsync      <= !((x_next >= HS_START) && (x_next < HS_END));
         vsync      <= !((y_next >= VS_START) && (y_next < VS_END));
      end
   end

endmodule

//--- logo_display.f
logic/logo_pkg.sv
logic/glyph_fetch_if.sv
logic/vga_sync.sv
logic/glyph_rom.sv
logic/rom_arbiter.sv
logic/sprite_engine.sv
logic/pixel_compositor.sv
logic/logo_display.sv
test/logo_display_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module logo_display_tb \
   -f logo_display.f -o logo_display_sim

./obj_dir/logo_display_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi

//--- test/logo_display_tb.sv
`timescale 1ns/1ps

module logo_display_tb;
   import logo_pkg::*;

   localparam rgb_t BG_COLOR       = 3'b001;
   localparam int   N_SPR          = 3;
   localparam int   RESET_CYCLES   = 3;
   localparam int   SEED           = 15419;
   localparam int   PRIORITY_LINES = 4;
   // lines 0 to 33 hold every sprite
   localparam int   CAP_LINES      = 34;
   // sync lock takes up to one frame and the checks two more
   localparam int   WATCHDOG_NS    = 3 * H_TOTAL * V_TOTAL * 10 + 100_000;

   logic clk;
   logic reset;
   logic hsync;
   logic vsync;
   rgb_t rgb;

   // sprite table and glyph bitmaps of the model
   int         spr_x [N_SPR];
   int         spr_y [N_SPR];
   int         spr_g [N_SPR];
   rgb_t       spr_c [N_SPR];
   glyph_row_t glyph_model [4][GLYPH_H];

   // top lines of the first checked frame
   rgb_t first_frame [CAP_LINES][H_ACTIVE];
   logic checked_line [CAP_LINES];

   // output position found from the sync edges
   int   out_x;
   int   out_y;
   int   cycle;
   int   last_vfall;
   int   errors;
   logic x_locked;
   logic y_locked;
   logic prev_hsync;
   logic prev_vsync;
   logic h_fell;
   logic h_rose;
   logic v_fell;
   logic v_rose;

   logo_display uut (
      .clk   (clk),
      .reset (reset),
      .hsync (hsync),
      .vsync (vsync),
      .rgb   (rgb)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_rgb(input string what, input int x, input int y,
                            input rgb_t got, input rgb_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] rgb %s x=%0d y=%0d got %h expected %h", what, x, y, got, exp);
      end
   endtask

   task automatic check_sync(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s at x=%0d y=%0d got %h expected %h", name, out_x, out_y, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
      begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // ------------------------------
   // screen model
   // ------------------------------
   function automatic glyph_row_t span(input int lo, input int hi);
      glyph_row_t r;
      int         c;
      r = '0;
      for (c = lo; c <= hi; c++)
         r[c] = 1'b1;
      return r;
   endfunction

   function automatic logic in_rect(input int s, input int x, input int y);
      return (x >= spr_x[s]) && (x < spr_x[s] + GLYPH_W) &&
             (y >= spr_y[s]) && (y < spr_y[s] + GLYPH_H);
   endfunction

   function automatic logic model_bit(input int s, input int x, input int y);
      return glyph_model[spr_g[s]][y - spr_y[s]][x - spr_x[s]];
   endfunction

   function automatic logic expected_hsync(input int x);
      return !((x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC));
   endfunction

   function automatic logic expected_vsync(input int y);
      return !((y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC));
   endfunction

   task automatic load_model();
      glyph_row_t bar;
      glyph_row_t wide;
      glyph_row_t sides;
      int         r;
      bar   = span(11, 20);
      wide  = span(10, 21);
      sides = span(10, 12) | span(19, 21);
      for (r = 0; r < GLYPH_H; r++)
      begin
         // zero is one ring
         glyph_model[GLYPH_ZERO][r] = (r == 0 || r == 15) ? bar :
                                      (r == 1 || r == 14) ? wide : sides;
         // one has a hook, a stem and a base
         glyph_model[GLYPH_ONE][r] = (r == 1 || r == 2) ? span(13, 17) :
                                     (r >= 14) ? span(12, 19) : span(15, 17);
         // seven is a top bar over right and middle strokes
         glyph_model[GLYPH_SEVEN][r] = (r <= 1) ? wide :
                                       (r <= 7) ? span(19, 21) : span(16, 18);
         // eight is two stacked loops
         glyph_model[GLYPH_EIGHT][r] = (r == 0 || r == 7 || r == 8 || r == 15) ? bar :
                                       (r == 1 || r == 14) ? wide : sides;
      end
      spr_x[0] = 300;
      spr_y[0] = 10;
      spr_g[0] = int'(GLYPH_EIGHT);
      spr_c[0] = 3'b101;
      spr_x[1] = 316;
      spr_y[1] = 18;
      spr_g[1] = int'(GLYPH_ZERO);
      spr_c[1] = 3'b011;
      spr_x[2] = 100;
      spr_y[2] = 10;
      spr_g[2] = int'(GLYPH_SEVEN);
      spr_c[2] = 3'b110;
      for (r = 0; r < CAP_LINES; r++)
         checked_line[r] = 1'b0;
   endtask

   // ------------------------------
   // one clock sampled 2 ns after the edge
   // ------------------------------
   task automatic step();
      @(posedge clk);
      #2;
      cycle++;
      h_fell     = prev_hsync && !hsync;
      h_rose     = !prev_hsync && hsync;
      v_fell     = prev_vsync && !vsync;
      v_rose     = !prev_vsync && vsync;
      prev_hsync = hsync;
      prev_vsync = vsync;
      if (out_x == H_TOTAL - 1)
      begin
         out_x = 0;
         out_y = (out_y == V_TOTAL - 1) ? 0 : out_y + 1;
      end
      else
         out_x++;
      // first hsync edge gives the column
      if (h_fell && !x_locked)
      begin
         out_x    = H_ACTIVE + H_FRONT;
         x_locked = 1'b1;
      end
      // first vsync edge gives the line
      if (v_fell && !y_locked)
      begin
         out_y      = V_ACTIVE + V_FRONT;
         y_locked   = 1'b1;
         last_vfall = cycle;
      end
      else if (v_fell)
      begin
         check_count("vsync period clocks", cycle - last_vfall, H_TOTAL * V_TOTAL);
         last_vfall = cycle;
      end
      if (y_locked)
      begin
         check_sync("hsync", hsync, expected_hsync(out_x));
         check_sync("vsync", vsync, expected_vsync(out_y));
      end
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic test_reset();
      int k;
      for (k = 0; k < RESET_CYCLES; k++)
      begin
         @(posedge clk);
         #1;
         if (k == RESET_CYCLES - 1)
            reset = 1'b0;
         #1;
         check_sync("hsync", hsync, 1'b1);
         check_sync("vsync", vsync, 1'b1);
         check_rgb("in reset", 0, 0, rgb, 3'b000);
      end
      // first clock out of reset
      step();
      check_sync("hsync", hsync, 1'b1);
      check_sync("vsync", vsync, 1'b1);
      check_rgb("after reset", 0, 0, rgb, 3'b000);
   endtask

   task automatic wait_for_lock();
      while (!y_locked)
         step();
   endtask

   // runs from the vsync edge to the end of the frame
   task automatic test_sync_timing();
      int h_low;
      int v_low;
      int h_falls;
      int v_ends;
      int last_hfall;
      h_low      = 0;
      v_low      = 1;
      h_falls    = 0;
      v_ends     = 0;
      last_hfall = -1;
      while (!(out_x == H_TOTAL - 1 && out_y == V_TOTAL - 1))
      begin
         step();
         if (!hsync)
            h_low++;
         if (h_rose)
         begin
            check_count("hsync low clocks", h_low, H_SYNC);
            h_low = 0;
         end
         if (h_fell)
         begin
            if (last_hfall >= 0)
               check_count("hsync period clocks", cycle - last_hfall, H_TOTAL);
            last_hfall = cycle;
            h_falls++;
         end
         if (!vsync)
            v_low++;
         if (v_rose)
         begin
            check_count("vsync low clocks", v_low, V_SYNC * H_TOTAL);
            v_ends++;
         end
      end
      check_count("hsync pulses in vertical blanking", h_falls, V_TOTAL - V_ACTIVE - V_FRONT);
      check_count("vsync pulse ends", v_ends, 1);
   endtask

   // one whole frame that also keeps the sprite lines
   task automatic test_blanking_background();
      int   n;
      int   s;
      logic near_sprite;
      for (n = 0; n < H_TOTAL * V_TOTAL; n++)
      begin
         step();
         if (out_y < CAP_LINES && out_x < H_ACTIVE)
            first_frame[out_y][out_x] = rgb;
         near_sprite = 1'b0;
         for (s = 0; s < N_SPR; s++)
            if (in_rect(s, out_x, out_y))
               near_sprite = 1'b1;
         if (out_x >= H_ACTIVE || out_y >= V_ACTIVE)
            check_rgb("blanking", out_x, out_y, rgb, 3'b000);
         else if (!near_sprite)
            check_rgb("background", out_x, out_y, rgb, BG_COLOR);
      end
   endtask

   // every sprite outside the overlap of sprites 0 and 1
   task automatic test_glyph_rendering();
      int   x;
      int   y;
      int   s;
      rgb_t exp;
      for (y = 0; y < CAP_LINES; y++)
         for (x = 0; x < H_ACTIVE; x++)
            for (s = 0; s < N_SPR; s++)
               if (in_rect(s, x, y) && !(in_rect(0, x, y) && in_rect(1, x, y)))
               begin
                  exp = model_bit(s, x, y) ? spr_c[s] : BG_COLOR;
                  check_rgb("glyph", x, y, first_frame[y][x], exp);
                  checked_line[y] = 1'b1;
               end
   endtask

   task automatic test_priority();
      int   lo;
      int   hi;
      int   n;
      int   x;
      int   y;
      rgb_t exp;
      lo = (spr_y[0] > spr_y[1]) ? spr_y[0] : spr_y[1];
      hi = ((spr_y[0] < spr_y[1]) ? spr_y[0] : spr_y[1]) + GLYPH_H - 1;
      for (n = 0; n < PRIORITY_LINES; n++)
      begin
         y = int'($urandom_range(hi, lo));
         checked_line[y] = 1'b1;
         for (x = 0; x < H_ACTIVE; x++)
            if (in_rect(0, x, y) && in_rect(1, x, y))
            begin
               // sprite 0 over sprite 1 over background
               if (model_bit(0, x, y))
                  exp = spr_c[0];
               else if (model_bit(1, x, y))
                  exp = spr_c[1];
               else
                  exp = BG_COLOR;
               check_rgb("overlap", x, y, first_frame[y][x], exp);
            end
      end
   endtask

   // next frame up to the last checked line
   task automatic test_frame_repeat();
      int last_line;
      int y;
      last_line = 0;
      for (y = 0; y < CAP_LINES; y++)
         if (checked_line[y])
            last_line = y;
      while (!(out_y == last_line && out_x == H_TOTAL - 1))
      begin
         step();
         if (out_y < CAP_LINES && out_x < H_ACTIVE)
            if (checked_line[out_y])
               check_rgb("repeat", out_x, out_y, rgb, first_frame[out_y][out_x]);
      end
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial
   begin
      reset      = 1'b1;
      errors     = 0;
      cycle      = 0;
      out_x      = 0;
      out_y      = 0;
      last_vfall = 0;
      x_locked   = 1'b0;
      y_locked   = 1'b0;
      prev_hsync = 1'b1;
      prev_vsync = 1'b1;
      void'($urandom(SEED));
      load_model();
      test_reset();
      wait_for_lock();
      test_sync_timing();
      test_blanking_background();
      test_glyph_rendering();
      test_priority();
      test_frame_repeat();
      $display("error count: %0d", errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_NS);
      $display("timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
      $display("error count: %0d", errors);
      $display("Checks failed");
      $finish;
   end

endmodule
